// ==== verilog/axi_sram_pkg.sv ====
package axi_sram_pkg;

	// Bus word and strobe widths
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// Response codes on rresp and bresp
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Byte lanes with a set strobe take the new word, the others keep the old
	function automatic logic [data_width-1:0] merge_bytes(
		input logic [data_width-1:0] old_word,
		input logic [data_width-1:0] new_word,
		input logic [strb_width-1:0] strb
	);
		logic [data_width-1:0] result;

		result = old_word;
		for (int i = 0; i < strb_width; i++) begin
			if (strb[i]) begin
				result[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return result;
	endfunction

endpackage

// ==== verilog/axi_read_channel.sv ====
`timescale 1ns/1ns

module axi_read_channel #(
	parameter int addr_width = 32,
	parameter int mem_depth = 1024
) (
	input logic clock,
	input logic reset,

	input logic [addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,

	output logic [axi_sram_pkg::data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	output logic rd_req,
	output logic [$clog2(mem_depth):0] rd_index,
	input logic rd_grant,
	input logic [axi_sram_pkg::data_width-1:0] rd_data,
	input logic rd_error
);

	import axi_sram_pkg::*;

	localparam int word_bits = $clog2(mem_depth);

	// Array data arrives in the cycle after the grant
	logic rd_wait;

	// Any address bit above the memory range marks the index as out of range
	logic out_of_range;
	assign out_of_range = |araddr[addr_width-1:word_bits+2];

	// Handshake and request flags
	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			rd_req <= 1'b0;
			rd_wait <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_req <= 1'b1;
			end

			// Request drops once the array takes it
			if (rd_req && rd_grant) begin
				rd_req <= 1'b0;
				rd_wait <= 1'b1;
			end

			if (rd_wait) begin
				rd_wait <= 1'b0;
				rvalid <= 1'b1;
			end

			// R transfer reopens the address channel
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				arready <= 1'b1;
			end
		end
	end

	// Captured index and returned data
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			rd_index <= {out_of_range, araddr[word_bits+1:2]};
		end

		if (rd_wait) begin
			rdata <= rd_data;
			rresp <= rd_error ? resp_slverr : resp_okay;
		end
	end

endmodule

// ==== verilog/axi_write_channel.sv ====
`timescale 1ns/1ns

module axi_write_channel #(
	parameter int addr_width = 32,
	parameter int mem_depth = 1024
) (
	input logic clock,
	input logic reset,

	input logic [addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,

	input logic [axi_sram_pkg::data_width-1:0] wdata,
	input logic [axi_sram_pkg::strb_width-1:0] wstrb,
	input logic wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	output logic wr_req,
	output logic [$clog2(mem_depth):0] wr_index,
	output logic [axi_sram_pkg::data_width-1:0] wr_data,
	output logic [axi_sram_pkg::strb_width-1:0] wr_strb,
	input logic wr_grant,
	input logic wr_error
);

	import axi_sram_pkg::*;

	localparam int word_bits = $clog2(mem_depth);

	// Address and data are captured independently
	logic aw_held;
	logic w_held;

	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign b_fire = bvalid && bready;

	// Upper address bits set means beyond the array
	logic out_of_range;
	assign out_of_range = |awaddr[addr_width-1:word_bits+2];

	// Handshake state
	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b1;
			wready <= 1'b1;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			wr_req <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (aw_fire) begin
				awready <= 1'b0;
				aw_held <= 1'b1;
			end

			if (w_fire) begin
				wready <= 1'b0;
				w_held <= 1'b1;
			end

			// Both halves present, hand the write to the array
			if (aw_held && w_held) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				wr_req <= 1'b1;
			end

			if (wr_req && wr_grant) begin
				wr_req <= 1'b0;
				bvalid <= 1'b1;
			end

			// Both readys stay low until the response is taken
			if (b_fire) begin
				bvalid <= 1'b0;
				awready <= 1'b1;
				wready <= 1'b1;
			end
		end
	end

	// Captured payload
	always_ff @(posedge clock) begin
		if (aw_fire) begin
			wr_index <= {out_of_range, awaddr[word_bits+1:2]};
		end

		if (w_fire) begin
			wr_data <= wdata;
			wr_strb <= wstrb;
		end

		// Error comes back with the grant
		if (wr_req && wr_grant) begin
			bresp <= wr_error ? resp_slverr : resp_okay;
		end
	end

endmodule

// ==== verilog/sram_array.sv ====
`timescale 1ns/1ns

module sram_array #(
	parameter int mem_depth = 1024
) (
	input logic clock,
	input logic reset,

	input logic rd_req,
	input logic [$clog2(mem_depth):0] rd_index,
	output logic rd_grant,
	output logic [axi_sram_pkg::data_width-1:0] rd_data,
	output logic rd_error,

	input logic wr_req,
	input logic [$clog2(mem_depth):0] wr_index,
	input logic [axi_sram_pkg::data_width-1:0] wr_data,
	input logic [axi_sram_pkg::strb_width-1:0] wr_strb,
	output logic wr_grant,
	output logic wr_error
);

	import axi_sram_pkg::*;

	localparam int word_bits = $clog2(mem_depth);

	logic [data_width-1:0] mem [mem_depth];

	// Walks every word while reset is held
	logic [word_bits-1:0] sweep_index;

	logic rd_out_of_range;

	// Write owns the port when both ask
	assign wr_grant = wr_req;
	assign rd_grant = rd_req && !wr_req;

	assign wr_error = wr_index >= mem_depth;
	assign rd_out_of_range = rd_index >= mem_depth;

	always_ff @(posedge clock) begin
		if (reset) begin
			sweep_index <= sweep_index + 1'b1;
		end else begin
			sweep_index <= '0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem[sweep_index] <= '0;
		end else if (wr_grant && !wr_error) begin
			// Read-modify-write of the addressed word
			mem[wr_index[word_bits-1:0]] <= merge_bytes(mem[wr_index[word_bits-1:0]],
				wr_data, wr_strb);
		end

		if (rd_grant) begin
			rd_data <= rd_out_of_range ? '0 : mem[rd_index[word_bits-1:0]];
			rd_error <= rd_out_of_range;
		end
	end

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ns

module axi_sram #(
	parameter int addr_width = 32,
	parameter int mem_depth = 1024
) (
	input logic clock,
	input logic reset,

	input logic [addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,

	output logic [axi_sram_pkg::data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	input logic [addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,

	input logic [axi_sram_pkg::data_width-1:0] wdata,
	input logic [axi_sram_pkg::strb_width-1:0] wstrb,
	input logic wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready
);

	import axi_sram_pkg::*;

	// Word index carries one extra bit for out of range addresses
	localparam int index_width = $clog2(mem_depth) + 1;

	logic rd_req;
	logic [index_width-1:0] rd_index;
	logic rd_grant;
	logic [data_width-1:0] rd_data;
	logic rd_error;

	logic wr_req;
	logic [index_width-1:0] wr_index;
	logic [data_width-1:0] wr_data;
	logic [strb_width-1:0] wr_strb;
	logic wr_grant;
	logic wr_error;

	axi_read_channel #(
		.addr_width(addr_width),
		.mem_depth(mem_depth)
	) read_channel (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.rd_req(rd_req),
		.rd_index(rd_index),
		.rd_grant(rd_grant),
		.rd_data(rd_data),
		.rd_error(rd_error)
	);

	axi_write_channel #(
		.addr_width(addr_width),
		.mem_depth(mem_depth)
	) write_channel (
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.wr_req(wr_req),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.wr_grant(wr_grant),
		.wr_error(wr_error)
	);

	sram_array #(
		.mem_depth(mem_depth)
	) array (
		.clock(clock),
		.reset(reset),
		.rd_req(rd_req),
		.rd_index(rd_index),
		.rd_grant(rd_grant),
		.rd_data(rd_data),
		.rd_error(rd_error),
		.wr_req(wr_req),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.wr_grant(wr_grant),
		.wr_error(wr_error)
	);

endmodule

// ==== verif/axi_sram_properties.sv ====
`timescale 1ns/1ns

module axi_sram_properties (
	input logic clock,
	input logic reset,
	input logic arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	input logic awready,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready
);

	// Failed assertions so far
	int fail_count = 0;

	// R channel holds valid and payload while the master stalls
	r_stable: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("rvalid or R payload changed under back-pressure");
			fail_count++;
		end

	// B channel holds valid and response while the master stalls
	b_stable: assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("bvalid or bresp changed under back-pressure");
			fail_count++;
		end

	// No new read address while a read response is pending
	ar_closed: assert property (@(posedge clock) disable iff (reset)
		rvalid |-> !arready)
		else begin
			$error("arready high while a read is outstanding");
			fail_count++;
		end

	// Write channels stay closed until the response is taken
	aw_w_closed: assert property (@(posedge clock) disable iff (reset)
		bvalid |-> !awready && !wready)
		else begin
			$error("awready or wready high while bvalid is high");
			fail_count++;
		end

endmodule

// ==== verif/axi_sram_checker.sv ====
`timescale 1ns/1ns

module axi_sram_checker (
	input logic clock,
	input logic reset,
	input logic arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	input logic awready,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready
);

	// Expected responses in issue order
	logic [31:0] exp_rdata_q[$];
	logic [1:0] exp_rresp_q[$];
	logic [1:0] exp_bresp_q[$];

	int check_count = 0;
	int error_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	task automatic expect_read(input logic [31:0] data, input logic [1:0] resp);
		exp_rdata_q.push_back(data);
		exp_rresp_q.push_back(resp);
	endtask

	task automatic expect_write(input logic [1:0] resp);
		exp_bresp_q.push_back(resp);
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// Port levels with the bus idle
	task automatic check_idle();
		compare_value("arready", {31'b0, arready}, 32'd1);
		compare_value("awready", {31'b0, awready}, 32'd1);
		compare_value("wready", {31'b0, wready}, 32'd1);
		compare_value("rvalid", {31'b0, rvalid}, 32'd0);
		compare_value("bvalid", {31'b0, bvalid}, 32'd0);
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	always @(posedge clock) begin
		if (!reset && rvalid && rready) begin
			if (exp_rdata_q.size() == 0) begin
				error_count++;
				$display("Read response at %0t ns that no read asked for", $time);
			end else begin
				compare_value("rdata", rdata, exp_rdata_q.pop_front());
				compare_value("rresp", {30'b0, rresp}, {30'b0, exp_rresp_q.pop_front()});
			end
		end
		if (!reset && bvalid && bready) begin
			if (exp_bresp_q.size() == 0) begin
				error_count++;
				$display("Write response at %0t ns that no write asked for", $time);
			end else begin
				compare_value("bresp", {30'b0, bresp}, {30'b0, exp_bresp_q.pop_front()});
			end
		end
	end

endmodule

// ==== verif/axi_sram_tb.sv ====
`timescale 1ns/1ns

module axi_sram_tb;

	import axi_sram_pkg::*;

	localparam int mem_depth = 256;
	localparam int reset_cycles = 16 + mem_depth + 4;
	// Transactions per test, in order
	localparam int tx_total = 8 + 16 + 24 + 6 + 6 + 200;
	localparam int timeout_limit = tx_total * 40 + reset_cycles;

	logic clock;
	logic reset;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	integer seed = 51313;
	bit stall_enable = 0;
	int cycle_count = 0;
	logic [31:0] shadow [mem_depth];

	axi_sram #(.addr_width(32), .mem_depth(mem_depth)) uut (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	axi_sram_checker response_checker (
		.clock(clock), .reset(reset),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awready(awready), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	bind axi_sram axi_sram_properties properties (
		.clock(clock), .reset(reset),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awready(awready), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	initial begin
		clock = 0;
		forever #10 clock = ~clock;
	end

	// Expected read word and response for a byte address
	function automatic logic [31:0] ref_read(input logic [31:0] addr, output logic [1:0] resp);
		logic [31:0] index;

		index = addr >> 2;
		if (index >= mem_depth) begin
			resp = resp_slverr;
			return 32'h0;
		end
		resp = resp_okay;
		return shadow[index];
	endfunction

	function automatic logic [1:0] ref_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] index;

		index = addr >> 2;
		if (index >= mem_depth) begin
			return resp_slverr;
		end
		shadow[index] = merge_bytes(shadow[index], data, strb);
		return resp_okay;
	endfunction

	function automatic logic pick_ready();
		if (!stall_enable) begin
			return 1'b1;
		end
		return ($random(seed) & 3) != 0;
	endfunction

	// Word-aligned address, now and then beyond the array
	function automatic logic [31:0] random_address();
		logic [31:0] addr;

		addr = ($random(seed) & 32'h3ff) & ~32'h3;
		if (($random(seed) & 7) == 0) begin
			addr = addr | 32'h1000;
		end
		return addr;
	endfunction

	task automatic read_word(input logic [31:0] addr);
		logic [31:0] exp_data;
		logic [1:0] exp_resp;

		exp_data = ref_read(addr, exp_resp);
		response_checker.expect_read(exp_data, exp_resp);
		@(posedge clock);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clock);
		while (!arready) @(posedge clock);
		arvalid <= 1'b0;
		rready <= pick_ready();
		@(posedge clock);
		while (!(rvalid && rready)) begin
			rready <= pick_ready();
			@(posedge clock);
		end
		rready <= 1'b0;
	endtask

	// Order 0 sends AW and W together, 1 AW first, 2 W first
	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int order);
		bit aw_done;
		bit w_done;

		aw_done = 0;
		w_done = 0;
		response_checker.expect_write(ref_write(addr, data, strb));
		@(posedge clock);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= (order != 2);
		wvalid <= (order != 1);
		while (!(aw_done && w_done)) begin
			@(posedge clock);
			if (!aw_done && awvalid && awready) begin
				aw_done = 1;
				awvalid <= 1'b0;
			end
			if (!w_done && wvalid && wready) begin
				w_done = 1;
				wvalid <= 1'b0;
				// Second half goes out once the first is taken
				if (order == 2) begin
					awvalid <= 1'b1;
				end
			end
			if (order == 1 && aw_done && !w_done && !wvalid) begin
				wvalid <= 1'b1;
			end
		end
		bready <= pick_ready();
		@(posedge clock);
		while (!(bvalid && bready)) begin
			bready <= pick_ready();
			@(posedge clock);
		end
		bready <= 1'b0;
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Errors found");
			$display("Timeout: the DUT stopped answering before the tests finished");
			$finish;
		end
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] read_addr;
		logic [31:0] rand_data;
		logic [3:0] rand_strb;
		int rand_order;
		int delay;
		int kind;

		reset = 1;
		araddr = 0;
		arvalid = 0;
		rready = 0;
		awaddr = 0;
		awvalid = 0;
		wdata = 0;
		wstrb = 0;
		wvalid = 0;
		bready = 0;
		for (int i = 0; i < mem_depth; i++) begin
			shadow[i] = 32'h0;
		end
		// Held past the clearing sweep of the array
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		response_checker.check_idle();
		read_word(32'h0);
		read_word(32'h3fc);
		for (int i = 0; i < 6; i++) begin
			read_word(($random(seed) & 32'h3ff) & ~32'h3);
		end
		response_checker.finish_test("Reset state");

		for (int i = 0; i < 8; i++) begin
			write_word(i * 4, 32'h1000_0000 + i * 32'h0101_0101, 4'hf, 0);
		end
		for (int i = 0; i < 8; i++) begin
			read_word(i * 4);
		end
		response_checker.finish_test("Full strobe write and read");

		for (int i = 0; i < 8; i++) begin
			addr = 32'h100 + i * 4;
			write_word(addr, 32'hdead_beef, 4'hf, 0);
			write_word(addr, 32'h1234_5678 ^ i, i[3:0] + 4'd1, 0);
			read_word(addr);
		end
		response_checker.finish_test("Partial strobes");

		write_word(32'h200, 32'hcafe_0001, 4'hf, 0);
		write_word(32'h204, 32'hcafe_0001, 4'hf, 1);
		write_word(32'h208, 32'hcafe_0001, 4'hf, 2);
		read_word(32'h200);
		read_word(32'h204);
		read_word(32'h208);
		response_checker.finish_test("AW and W ordering");

		// Low bits alias words 2 and 4, which must keep their data
		write_word(mem_depth * 4 + 8, 32'hffff_ffff, 4'hf, 0);
		write_word(32'h8000_0010, 32'hffff_ffff, 4'hf, 2);
		read_word(mem_depth * 4 + 8);
		read_word(32'h8000_0010);
		read_word(32'h8);
		read_word(32'h10);
		response_checker.finish_test("Out of range");

		stall_enable = 1;
		for (int i = 0; i < 200; i++) begin
			addr = random_address();
			kind = $random(seed) & 3;
			if (kind == 0) begin
				write_word(addr, $random(seed), $random(seed), ($random(seed) & 32'h7fff) % 3);
			end else if (kind == 1) begin
				read_word(addr);
			end else begin
				read_addr = random_address();
				if ((read_addr >> 2) == (addr >> 2)) begin
					read_addr = read_addr ^ 32'h4;
				end
				rand_data = $random(seed);
				rand_strb = $random(seed);
				rand_order = ($random(seed) & 32'h7fff) % 3;
				delay = $random(seed) & 3;
				// Read and write overlap on different words, so the array arbitrates
				fork
					write_word(addr, rand_data, rand_strb, rand_order);
					begin
						repeat (delay) @(posedge clock);
						read_word(read_addr);
					end
				join
			end
		end
		repeat (4) @(posedge clock);
		response_checker.check_idle();
		response_checker.finish_test("Random traffic");

		$display("Total: %0d checks, %0d errors, %0d assertion failures",
			response_checker.check_count, response_checker.error_count,
			uut.properties.fail_count);
		if (response_checker.error_count == 0 && uut.properties.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== axi_sram.f ====
verilog/axi_sram_pkg.sv
verilog/axi_read_channel.sv
verilog/axi_write_channel.sv
verilog/sram_array.sv
verilog/axi_sram.sv
verif/axi_sram_properties.sv
verif/axi_sram_checker.sv
verif/axi_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the axi_sram testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module axi_sram_tb \
	-f axi_sram.f \
	--Mdir obj_dir -o axi_sram_sim

./obj_dir/axi_sram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "No errors" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
